//--- Bender.yml
package:
  name: cache_two_level

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/cache_pkg.sv
      - hw/l1_cache.sv
      - hw/l2_cache.sv
      - hw/main_memory.sv
      - hw/cache_ctrl.sv
      - hw/cache_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/cache_assert.sv
      - verif/cache_tb.sv

//--- hw/cache_ctrl.sv
`include "cache_cfg.svh"

module cache_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  logic              write,
    input  cache_pkg::addr_t   addr,
    input  cache_pkg::nibble_t wdata,
    input  logic              l1_hit,
    input  cache_pkg::nibble_t l1_rd_nibble,
    input  logic              l1_victim_valid,
    input  cache_pkg::blk_id_t l1_victim_blk,
    input  cache_pkg::block_t  l1_victim_block,
    input  logic              l2_hit,
    input  cache_pkg::block_t  l2_hit_block,
    input  logic              l2_wb_present,
    input  logic              l2_victim_valid,
    input  cache_pkg::blk_id_t l2_victim_blk,
    input  cache_pkg::block_t  l2_victim_block,
    input  logic              mem_rd_done,
    input  cache_pkg::block_t  mem_rd_block,
    output cache_pkg::addr_t   l1_addr,
    output logic              l1_wr_en,
    output cache_pkg::nibble_t l1_wdata,
    output logic              l1_fill_en,
    output cache_pkg::block_t  l1_fill_block,
    output cache_pkg::addr_t   l2_addr,
    output logic              l2_wr_en,
    output cache_pkg::nibble_t l2_wdata,
    output logic              l2_touch_en,
    output logic              l2_fill_en,
    output cache_pkg::block_t  l2_fill_block,
    output cache_pkg::blk_id_t l2_wb_blk,
    output logic              l2_wb_en,
    output cache_pkg::block_t  l2_wb_block,
    output logic              mem_rd_start,
    output cache_pkg::blk_id_t mem_rd_blk,
    output logic              mem_wr_en,
    output cache_pkg::blk_id_t mem_wr_blk,
    output cache_pkg::block_t  mem_wr_block,
    output logic              mem_nib_wr_en,
    output cache_pkg::addr_t   mem_nib_addr,
    output cache_pkg::nibble_t mem_nib_data,
    output logic              done,
    output logic              busy,
    output cache_pkg::nibble_t rdata,
    output logic              hit_l1,
    output logic              hit_l2
);
    import cache_pkg::*;

    localparam int L2_LAT   = `CACHE_L2_LATENCY;
    localparam int CNT_BITS = $clog2(L2_LAT + 1);
    localparam int NIB      = `CACHE_NIBBLE_BITS;

    ctrl_state_t         state;
    logic [CNT_BITS-1:0] l2_cnt;   // Cycles already spent on the level-two latency
    addr_t               addr_q;   // Request held while busy
    logic                write_q;
    nibble_t             wdata_q;
    offset_t             req_off;
    logic                l1_fill_l2_hit;

    assign req_off = addr_q[`CACHE_OFFSET_BITS-1:0];
    assign busy    = (state != IDLE);
    assign done    = (state == RESPOND);

    ////////////////////////////////////////////////////////////
    // Storage commands, decoded from the state
    ////////////////////////////////////////////////////////////
    assign l1_addr  = (state == IDLE) ? addr : addr_q;  // IDLE looks up the live request
    assign l1_wr_en = (state == IDLE) && req && write && l1_hit;
    assign l1_wdata = wdata;

    // Level one is refilled after a read hit in level two or after a memory fetch
    assign l1_fill_l2_hit = (state == L2_RESOLVE) && !write_q && l2_hit;
    assign l1_fill_en     = l1_fill_l2_hit || (state == L1_FILL);
    assign l1_fill_block  = (state == L1_FILL) ? mem_rd_block : l2_hit_block;

    assign l2_addr       = addr_q;
    assign l2_wr_en      = (state == L2_RESOLVE) && write_q && l2_hit;
    assign l2_wdata      = wdata_q;
    assign l2_touch_en   = (state == L2_RESOLVE) && l2_hit;
    assign l2_fill_en    = (state == L2_FILL);
    assign l2_fill_block = mem_rd_block;

    // The displaced level-one line goes to level two when it is held there
    assign l2_wb_en    = l1_fill_en && l1_victim_valid;
    assign l2_wb_blk   = l1_victim_blk;
    assign l2_wb_block = l1_victim_block;

    assign mem_rd_start = (state == L2_RESOLVE) && !l2_hit;
    assign mem_rd_blk   = addr_q[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS];

    // Memory takes the level-two victim during L2_FILL, else an orphaned level-one victim
    assign mem_wr_en    = ((state == L2_FILL) && l2_victim_valid) ||
                          (l1_fill_en && l1_victim_valid && !l2_wb_present);
    assign mem_wr_blk   = (state == L2_FILL) ? l2_victim_blk : l1_victim_blk;
    assign mem_wr_block = (state == L2_FILL) ? l2_victim_block : l1_victim_block;

    // No write allocate, a double miss writes straight into memory
    assign mem_nib_wr_en = (state == MEM_WAIT) && mem_rd_done && write_q;
    assign mem_nib_addr  = addr_q;
    assign mem_nib_data  = wdata_q;

    ////////////////////////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= IDLE;
            l2_cnt <= '0;
            rdata  <= '0;
            hit_l1 <= 1'b0;
            hit_l2 <= 1'b0;
        end
        else
        begin
            rdata  <= '0;    // Response fields only live in the done cycle
            hit_l1 <= 1'b0;
            hit_l2 <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (req && l1_hit)
                    begin
                        hit_l1 <= 1'b1;
                        if (!write)
                            rdata <= l1_rd_nibble;
                        state <= RESPOND;
                    end
                    else if (req)
                    begin
                        l2_cnt <= CNT_BITS'(1);
                        state  <= L2_WAIT;
                    end
                end
                L2_WAIT:
                begin
                    if (l2_cnt == CNT_BITS'(L2_LAT - 1))
                        state <= L2_RESOLVE;
                    else
                        l2_cnt <= l2_cnt + 1'b1;
                end
                L2_RESOLVE:
                begin
                    if (l2_hit)
                    begin
                        hit_l2 <= 1'b1;
                        if (!write_q)
                            rdata <= l2_hit_block[req_off*NIB +: NIB];
                        state <= RESPOND;
                    end
                    else
                        state <= MEM_WAIT;  // Memory read starts this cycle
                end
                MEM_WAIT:
                begin
                    if (mem_rd_done)
                        state <= write_q ? RESPOND : L2_FILL;
                end
                L2_FILL:
                    state <= L1_FILL;
                L1_FILL:
                begin
                    rdata <= mem_rd_block[req_off*NIB +: NIB];
                    state <= RESPOND;
                end
                default:
                    state <= IDLE;  // RESPOND lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == IDLE) && req)
        begin
            addr_q  <= addr;
            write_q <= write;
            wdata_q <= wdata;
        end
    end

endmodule

//--- hw/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    // Full nibble address as issued by the requester
    typedef logic [`CACHE_ADDR_BITS-1:0] addr_t;

    // Memory block number, which is the address with its offset stripped
    typedef logic [`CACHE_ADDR_BITS-`CACHE_OFFSET_BITS-1:0] blk_id_t;

    typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;  // Nibble position inside a block
    typedef logic [`CACHE_NIBBLE_BITS-1:0] nibble_t;

    // Nibble k sits at bits 4k+3 down to 4k
    typedef logic [(`CACHE_NIBBLE_BITS << `CACHE_OFFSET_BITS)-1:0] block_t;

    typedef logic [$clog2(`CACHE_L2_WAYS)-1:0] way_t;  // Level-two way number and LRU rank

    ////////////////////////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,        // Waiting for a request, level-one lookup on the live address
        L2_WAIT,     // Level-two latency is running
        L2_RESOLVE,  // Level-two hit or miss is acted on
        MEM_WAIT,    // Memory read in flight
        L2_FILL,     // Fetched block enters level two
        L1_FILL,     // Fetched block enters level one
        RESPOND      // done cycle
    } ctrl_state_t;

endpackage

//--- hw/cache_top.sv
module cache_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  logic              write,
    input  cache_pkg::addr_t   addr,
    input  cache_pkg::nibble_t wdata,
    output logic              done,
    output logic              busy,
    output cache_pkg::nibble_t rdata,
    output logic              hit_l1,
    output logic              hit_l2
);
    import cache_pkg::*;

    // Level-one side
    addr_t   l1_addr;
    logic    l1_wr_en;
    nibble_t l1_wdata;
    logic    l1_fill_en;
    block_t  l1_fill_block;
    logic    l1_hit;
    nibble_t l1_rd_nibble;
    logic    l1_victim_valid;
    blk_id_t l1_victim_blk;
    block_t  l1_victim_block;

    // Level-two side
    addr_t   l2_addr;
    logic    l2_wr_en;
    nibble_t l2_wdata;
    logic    l2_touch_en;
    logic    l2_fill_en;
    block_t  l2_fill_block;
    blk_id_t l2_wb_blk;
    logic    l2_wb_en;
    block_t  l2_wb_block;
    logic    l2_hit;
    block_t  l2_hit_block;
    logic    l2_wb_present;
    logic    l2_victim_valid;
    blk_id_t l2_victim_blk;
    block_t  l2_victim_block;

    // Memory side
    logic    mem_rd_start;
    blk_id_t mem_rd_blk;
    logic    mem_wr_en;
    blk_id_t mem_wr_blk;
    block_t  mem_wr_block;
    logic    mem_nib_wr_en;
    addr_t   mem_nib_addr;
    nibble_t mem_nib_data;
    logic    mem_rd_done;
    block_t  mem_rd_block;

    cache_ctrl cache_ctrl_inst (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .write           (write),
        .addr            (addr),
        .wdata           (wdata),
        .l1_hit          (l1_hit),
        .l1_rd_nibble    (l1_rd_nibble),
        .l1_victim_valid (l1_victim_valid),
        .l1_victim_blk   (l1_victim_blk),
        .l1_victim_block (l1_victim_block),
        .l2_hit          (l2_hit),
        .l2_hit_block    (l2_hit_block),
        .l2_wb_present   (l2_wb_present),
        .l2_victim_valid (l2_victim_valid),
        .l2_victim_blk   (l2_victim_blk),
        .l2_victim_block (l2_victim_block),
        .mem_rd_done     (mem_rd_done),
        .mem_rd_block    (mem_rd_block),
        .l1_addr         (l1_addr),
        .l1_wr_en        (l1_wr_en),
        .l1_wdata        (l1_wdata),
        .l1_fill_en      (l1_fill_en),
        .l1_fill_block   (l1_fill_block),
        .l2_addr         (l2_addr),
        .l2_wr_en        (l2_wr_en),
        .l2_wdata        (l2_wdata),
        .l2_touch_en     (l2_touch_en),
        .l2_fill_en      (l2_fill_en),
        .l2_fill_block   (l2_fill_block),
        .l2_wb_blk       (l2_wb_blk),
        .l2_wb_en        (l2_wb_en),
        .l2_wb_block     (l2_wb_block),
        .mem_rd_start    (mem_rd_start),
        .mem_rd_blk      (mem_rd_blk),
        .mem_wr_en       (mem_wr_en),
        .mem_wr_blk      (mem_wr_blk),
        .mem_wr_block    (mem_wr_block),
        .mem_nib_wr_en   (mem_nib_wr_en),
        .mem_nib_addr    (mem_nib_addr),
        .mem_nib_data    (mem_nib_data),
        .done            (done),
        .busy            (busy),
        .rdata           (rdata),
        .hit_l1          (hit_l1),
        .hit_l2          (hit_l2)
    );

    l1_cache l1_cache_inst (
        .clk          (clk),
        .reset        (reset),
        .addr         (l1_addr),
        .wr_en        (l1_wr_en),
        .wdata        (l1_wdata),
        .fill_en      (l1_fill_en),
        .fill_block   (l1_fill_block),
        .hit          (l1_hit),
        .rd_nibble    (l1_rd_nibble),
        .victim_valid (l1_victim_valid),
        .victim_blk   (l1_victim_blk),
        .victim_block (l1_victim_block)
    );

    l2_cache l2_cache_inst (
        .clk          (clk),
        .reset        (reset),
        .addr         (l2_addr),
        .wr_en        (l2_wr_en),
        .wdata        (l2_wdata),
        .touch_en     (l2_touch_en),
        .fill_en      (l2_fill_en),
        .fill_block   (l2_fill_block),
        .wb_blk       (l2_wb_blk),
        .wb_en        (l2_wb_en),
        .wb_block     (l2_wb_block),
        .hit          (l2_hit),
        .hit_block    (l2_hit_block),
        .wb_present   (l2_wb_present),
        .victim_valid (l2_victim_valid),
        .victim_blk   (l2_victim_blk),
        .victim_block (l2_victim_block)
    );

    main_memory main_memory_inst (
        .clk       (clk),
        .reset     (reset),
        .rd_start  (mem_rd_start),
        .rd_blk    (mem_rd_blk),
        .wr_en     (mem_wr_en),
        .wr_blk    (mem_wr_blk),
        .wr_block  (mem_wr_block),
        .nib_wr_en (mem_nib_wr_en),
        .nib_addr  (mem_nib_addr),
        .nib_data  (mem_nib_data),
        .rd_done   (mem_rd_done),
        .rd_block  (mem_rd_block)
    );

endmodule

//--- hw/l1_cache.sv
`include "cache_cfg.svh"

module l1_cache (
    input  logic              clk,
    input  logic              reset,
    input  cache_pkg::addr_t   addr,
    input  logic              wr_en,
    input  cache_pkg::nibble_t wdata,
    input  logic              fill_en,
    input  cache_pkg::block_t  fill_block,
    output logic              hit,
    output cache_pkg::nibble_t rd_nibble,
    output logic              victim_valid,
    output cache_pkg::blk_id_t victim_blk,
    output cache_pkg::block_t  victim_block
);
    import cache_pkg::*;

    localparam int IDX_BITS = `CACHE_L1_INDEX_BITS;
    localparam int BLK_BITS = `CACHE_ADDR_BITS - `CACHE_OFFSET_BITS;
    localparam int TAG_BITS = BLK_BITS - IDX_BITS;  // 2 bits with the default geometry
    localparam int LINES    = 1 << IDX_BITS;
    localparam int NIB      = `CACHE_NIBBLE_BITS;

    block_t              data_mem [LINES];  // One block per line
    logic [TAG_BITS-1:0] tag_mem  [LINES];
    logic [LINES-1:0]    valid;

    blk_id_t             blk;
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    offset_t             off;

    assign blk = addr[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS];
    assign idx = blk[IDX_BITS-1:0];           // Low block bits pick the line
    assign tag = blk[BLK_BITS-1:IDX_BITS];
    assign off = addr[`CACHE_OFFSET_BITS-1:0];

    // Lookup is purely combinational
    assign hit       = valid[idx] && (tag_mem[idx] == tag);
    assign rd_nibble = data_mem[idx][off*NIB +: NIB];

    // The current occupant of the line, which a fill will displace
    assign victim_valid = valid[idx];
    assign victim_blk   = {tag_mem[idx], idx};
    assign victim_block = data_mem[idx];

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            data_mem[idx] <= fill_block;
            tag_mem[idx]  <= tag;
        end
        else if (wr_en && hit)
            data_mem[idx][off*NIB +: NIB] <= wdata;  // Only the addressed nibble changes
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            valid <= '0;
        else if (fill_en)
            valid[idx] <= 1'b1;
    end

endmodule

//--- hw/l2_cache.sv
`include "cache_cfg.svh"

module l2_cache (
    input  logic              clk,
    input  logic              reset,
    input  cache_pkg::addr_t   addr,
    input  logic              wr_en,
    input  cache_pkg::nibble_t wdata,
    input  logic              touch_en,
    input  logic              fill_en,
    input  cache_pkg::block_t  fill_block,
    input  cache_pkg::blk_id_t wb_blk,
    input  logic              wb_en,
    input  cache_pkg::block_t  wb_block,
    output logic              hit,
    output cache_pkg::block_t  hit_block,
    output logic              wb_present,
    output logic              victim_valid,
    output cache_pkg::blk_id_t victim_blk,
    output cache_pkg::block_t  victim_block
);
    import cache_pkg::*;

    localparam int WAYS     = `CACHE_L2_WAYS;
    localparam int SET_BITS = `CACHE_L2_INDEX_BITS;
    localparam int SETS     = 1 << SET_BITS;
    localparam int BLK_BITS = `CACHE_ADDR_BITS - `CACHE_OFFSET_BITS;
    localparam int TAG_BITS = BLK_BITS - SET_BITS;
    localparam int NIB      = `CACHE_NIBBLE_BITS;

    block_t              data_mem [SETS][WAYS];
    logic [TAG_BITS-1:0] tag_mem  [SETS][WAYS];
    logic [WAYS-1:0]     valid    [SETS];
    way_t                rank     [SETS][WAYS];  // 0 is the least recently used way

    blk_id_t             blk;
    logic [SET_BITS-1:0] set_idx;
    logic [TAG_BITS-1:0] tag;
    offset_t             off;
    logic [SET_BITS-1:0] wb_set;
    logic [TAG_BITS-1:0] wb_tag;
    way_t                hit_way;
    way_t                victim_way;
    way_t                wb_way;
    way_t                promote_way;
    logic                promote;

    assign blk     = addr[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS];
    assign set_idx = blk[SET_BITS-1:0];
    assign tag     = blk[BLK_BITS-1:SET_BITS];
    assign off     = addr[`CACHE_OFFSET_BITS-1:0];
    assign wb_set  = wb_blk[SET_BITS-1:0];  // Second lookup for the level-one victim
    assign wb_tag  = wb_blk[BLK_BITS-1:SET_BITS];

    ////////////////////////////////////////////////////////////
    // Way search on both lookup ports
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        hit        = 1'b0;
        hit_way    = '0;
        victim_way = '0;
        wb_present = 1'b0;
        wb_way     = '0;
        for (int w = 0; w < WAYS; w++)
        begin
            if (valid[set_idx][w] && (tag_mem[set_idx][w] == tag))
            begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
            if (rank[set_idx][w] == '0)
                victim_way = way_t'(w);  // Exactly one way of a set holds rank 0
            if (valid[wb_set][w] && (tag_mem[wb_set][w] == wb_tag))
            begin
                wb_present = 1'b1;
                wb_way     = way_t'(w);
            end
        end
    end

    assign hit_block    = data_mem[set_idx][hit_way];
    assign victim_valid = valid[set_idx][victim_way];
    assign victim_blk   = {tag_mem[set_idx][victim_way], set_idx};
    assign victim_block = data_mem[set_idx][victim_way];

    // A fill promotes the way it lands in, a touch promotes the hit way
    assign promote_way = fill_en ? victim_way : hit_way;
    assign promote     = fill_en || (touch_en && hit);

    always_ff @(posedge clk)
    begin
        if (wr_en && hit)
            data_mem[set_idx][hit_way][off*NIB +: NIB] <= wdata;
        if (wb_en && wb_present)
            data_mem[wb_set][wb_way] <= wb_block;  // Overwrite in place, LRU untouched
        if (fill_en)
        begin
            data_mem[set_idx][victim_way] <= fill_block;
            tag_mem[set_idx][victim_way]  <= tag;
        end
    end

    ////////////////////////////////////////////////////////////
    // Valid bits and LRU ranks
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                valid[s] <= '0;
                for (int w = 0; w < WAYS; w++)
                    rank[s][w] <= way_t'(w);  // Way 0 starts as the eviction candidate
            end
        end
        else
        begin
            if (fill_en)
                valid[set_idx][victim_way] <= 1'b1;
            if (promote)
            begin
                for (int w = 0; w < WAYS; w++)
                begin
                    if (way_t'(w) == promote_way)
                        rank[set_idx][w] <= way_t'(WAYS - 1);
                    else if (rank[set_idx][w] > rank[set_idx][promote_way])
                        rank[set_idx][w] <= rank[set_idx][w] - 1'b1;  // Close the gap
                end
            end
        end
    end

endmodule

//--- hw/main_memory.sv
`include "cache_cfg.svh"

module main_memory (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_start,
    input  cache_pkg::blk_id_t rd_blk,
    input  logic              wr_en,
    input  cache_pkg::blk_id_t wr_blk,
    input  cache_pkg::block_t  wr_block,
    input  logic              nib_wr_en,
    input  cache_pkg::addr_t   nib_addr,
    input  cache_pkg::nibble_t nib_data,
    output logic              rd_done,
    output cache_pkg::block_t  rd_block
);
    import cache_pkg::*;

    localparam int BLOCKS   = `CACHE_MEM_BLOCKS;
    localparam int LAT      = `CACHE_MEM_LATENCY;
    localparam int CNT_BITS = $clog2(LAT + 1);
    localparam int NIB      = `CACHE_NIBBLE_BITS;

    block_t              mem [BLOCKS];
    blk_id_t             rd_blk_q;  // Block number held for the length of the read
    logic [CNT_BITS-1:0] rd_cnt;    // Cycles left before the data returns, 0 when idle

    // Block i powers up holding the value i
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < BLOCKS; i++)
                mem[i] <= block_t'(i);
        end
        else if (wr_en)
            mem[wr_blk] <= wr_block;  // Write-back of a whole evicted block
        else if (nib_wr_en)
            mem[nib_addr[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS]]
                [nib_addr[`CACHE_OFFSET_BITS-1:0]*NIB +: NIB] <= nib_data;
    end

    ////////////////////////////////////////////////////////////
    // Read latency counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_cnt  <= '0;
            rd_done <= 1'b0;
        end
        else
        begin
            if (rd_start)
                rd_cnt <= CNT_BITS'(LAT - 1);
            else if (rd_cnt != '0)
                rd_cnt <= rd_cnt - 1'b1;
            rd_done <= (rd_cnt == CNT_BITS'(1)) && !rd_start;  // LAT cycles after rd_start
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_start)
            rd_blk_q <= rd_blk;
        if (rd_cnt == CNT_BITS'(1))
            rd_block <= mem[rd_blk_q];  // Held until the next read completes
    end

endmodule

//--- include/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Geometry of the request address and the data items
`define CACHE_ADDR_BITS     7  // Nibble address into the 32-block memory
`define CACHE_OFFSET_BITS   2  // Four nibbles per block
`define CACHE_NIBBLE_BITS   4  // One data item

// Level one is direct mapped, level two is set associative
`define CACHE_L1_INDEX_BITS 3  // 8 lines
`define CACHE_L2_INDEX_BITS 4  // 16 sets
`define CACHE_L2_WAYS       4

`define CACHE_MEM_BLOCKS    32

// Access latencies in clk cycles
`define CACHE_L2_LATENCY    2
`define CACHE_MEM_LATENCY   5

`endif

//--- verif/cache_assert.sv
module cache_assert (
    input logic clk,
    input logic reset,
    input logic done,
    input logic busy,
    input logic hit_l1,
    input logic hit_l2
);
    int fail_count = 0;  // Number of failed checks, read from the testbench

    // done is a single-cycle strobe
    done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else
    begin
        fail_count++;
        $error("done stayed high for more than one cycle");
    end

    // A request hits one level at most
    hits_exclusive: assert property (@(posedge clk) disable iff (reset) !(hit_l1 && hit_l2))
    else
    begin
        fail_count++;
        $error("hit_l1 and hit_l2 are high together");
    end

    done_while_busy: assert property (@(posedge clk) disable iff (reset) done |-> busy)
    else
    begin
        fail_count++;
        $error("done came while busy was low");
    end

    idle_after_reset: assert property (@(posedge clk) reset |=> !busy)  // No request survives reset
    else
    begin
        fail_count++;
        $error("busy was high in the cycle after reset");
    end

endmodule

bind cache_top cache_assert cache_assert_inst (
    .clk    (clk),
    .reset  (reset),
    .done   (done),
    .busy   (busy),
    .hit_l1 (hit_l1),
    .hit_l2 (hit_l2)
);

//--- verif/cache_tb.sv
`include "cache_cfg.svh"

module cache_tb;
    import cache_pkg::*;

    // Hit classes of the request table
    localparam int HIT_NONE = 0;
    localparam int HIT_L1   = 1;
    localparam int HIT_L2   = 2;

    // Expected latencies, req edge to done cycle
    localparam int LAT_L1      = 1;
    localparam int LAT_L2      = `CACHE_L2_LATENCY + 1;
    localparam int LAT_WR_MISS = `CACHE_L2_LATENCY + `CACHE_MEM_LATENCY + 1;
    localparam int LAT_RD_MISS = `CACHE_L2_LATENCY + `CACHE_MEM_LATENCY + 3;  // Two fill cycles

    logic    clk;
    logic    reset;
    logic    req;
    logic    write;
    addr_t   addr;
    nibble_t wdata;
    logic    done;
    logic    busy;
    nibble_t rdata;
    logic    hit_l1;
    logic    hit_l2;

    // Request table, one entry per request
    logic    tbl_write [$];
    addr_t   tbl_addr  [$];
    nibble_t tbl_wdata [$];
    int      tbl_class [$];
    int      tbl_lat   [$];

    nibble_t shadow [1 << `CACHE_ADDR_BITS];  // Reference copy of every memory nibble
    int      cycle_count = 0;
    int      cycle_limit = 1000;  // Replaced once the table is built
    int      cycles;
    nibble_t exp_rdata;

    cache_top cache_top_inst (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .write  (write),
        .addr   (addr),
        .wdata  (wdata),
        .done   (done),
        .busy   (busy),
        .rdata  (rdata),
        .hit_l1 (hit_l1),
        .hit_l2 (hit_l2)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;  // Period of 4

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic add_req(input logic wr, input int blk, input int off,
                           input nibble_t data, input int hit_class, input int lat);
        tbl_write.push_back(wr);
        tbl_addr.push_back(addr_t'((blk << `CACHE_OFFSET_BITS) + off));
        tbl_wdata.push_back(data);
        tbl_class.push_back(hit_class);
        tbl_lat.push_back(lat);
    endtask

    // Block i starts out holding the value i, nibble k at bits 4k+3 down to 4k
    task automatic init_shadow();
        block_t blk_val;
        for (int b = 0; b < `CACHE_MEM_BLOCKS; b++)
        begin
            blk_val = block_t'(b);
            for (int k = 0; k < (1 << `CACHE_OFFSET_BITS); k++)
                shadow[(b << `CACHE_OFFSET_BITS) + k] = blk_val[k*4 +: 4];
        end
    endtask

    task automatic check_nibble(input string name, input nibble_t exp, input nibble_t act);
        if (act !== exp)
        begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_hits(input logic exp_l1, exp_l2, act_l1, act_l2);
        if ({act_l1, act_l2} !== {exp_l1, exp_l2})
        begin
            $display("ERR %0t hit_l1,hit_l2 expected %b%b actual %b%b",
                     $time, exp_l1, exp_l2, act_l1, act_l2);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (act != exp)
        begin
            $display("ERR %0t latency expected %0d actual %0d", $time, exp, act);
            abort_run();
        end
    endtask

    // Run limit, counted over the whole simulation including reset
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout: the requests did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial
    begin
        reset = 1'b1;
        req   = 1'b0;
        write = 1'b0;
        addr  = '0;
        wdata = '0;

        // Cold misses, then level-one and level-two read hits
        add_req(1'b0,  3, 0, 4'h0, HIT_NONE, LAT_RD_MISS);
        add_req(1'b0,  5, 1, 4'h0, HIT_NONE, LAT_RD_MISS);
        add_req(1'b0, 20, 1, 4'h0, HIT_NONE, LAT_RD_MISS);
        add_req(1'b0,  3, 0, 4'h0, HIT_L1,   LAT_L1);
        add_req(1'b0, 20, 0, 4'h0, HIT_L1,   LAT_L1);
        add_req(1'b0, 11, 0, 4'h0, HIT_NONE, LAT_RD_MISS);  // Pushes block 3 out of line 3
        add_req(1'b0,  3, 0, 4'h0, HIT_L2,   LAT_L2);
        // Write hits in both levels
        add_req(1'b1,  3, 2, 4'ha, HIT_L1,   LAT_L1);
        add_req(1'b0,  3, 2, 4'h0, HIT_L1,   LAT_L1);
        add_req(1'b1, 11, 1, 4'h5, HIT_L2,   LAT_L2);
        add_req(1'b0, 11, 1, 4'h0, HIT_L2,   LAT_L2);       // Dirty block 3 goes back to L2
        add_req(1'b0,  3, 2, 4'h0, HIT_L2,   LAT_L2);
        // Write miss lands in memory only
        add_req(1'b1,  9, 3, 4'hc, HIT_NONE, LAT_WR_MISS);
        add_req(1'b0,  9, 3, 4'h0, HIT_NONE, LAT_RD_MISS);
        add_req(1'b0,  9, 0, 4'h0, HIT_L1,   LAT_L1);
        // Conflict chain on line 1 with level-two sets 1 and 9
        add_req(1'b1,  9, 2, 4'h6, HIT_L1,   LAT_L1);
        add_req(1'b0,  1, 0, 4'h0, HIT_NONE, LAT_RD_MISS);
        add_req(1'b0, 17, 1, 4'h0, HIT_NONE, LAT_RD_MISS);
        add_req(1'b0, 25, 0, 4'h0, HIT_NONE, LAT_RD_MISS);
        add_req(1'b0,  9, 2, 4'h0, HIT_L2,   LAT_L2);       // Modified nibble survived
        add_req(1'b0,  1, 0, 4'h0, HIT_L2,   LAT_L2);
        add_req(1'b1, 25, 3, 4'hf, HIT_L2,   LAT_L2);
        add_req(1'b0, 25, 3, 4'h0, HIT_L2,   LAT_L2);
        add_req(1'b0, 17, 0, 4'h0, HIT_L2,   LAT_L2);
        add_req(1'b0, 17, 0, 4'h0, HIT_L1,   LAT_L1);
        add_req(1'b0, 25, 3, 4'h0, HIT_L2,   LAT_L2);

        cycle_limit = tbl_write.size() * 12 + 50;
        init_shadow();

        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        for (int i = 0; i < tbl_write.size(); i++)
        begin
            @(posedge clk);
            #1;
            check_flag("busy", 1'b0, busy);  // Idle between requests
            req   = 1'b1;  // One-cycle strobe
            write = tbl_write[i];
            addr  = tbl_addr[i];
            wdata = tbl_wdata[i];

            cycles = 0;
            @(posedge clk);
            #1;
            req = 1'b0;
            cycles++;
            check_flag("busy", 1'b1, busy);
            while (done !== 1'b1)
            begin
                @(posedge clk);
                #1;
                cycles++;
                check_flag("busy", 1'b1, busy);  // Held up to and including done
            end

            // A write answers with 0 and updates the reference copy
            if (tbl_write[i])
            begin
                exp_rdata = '0;
                shadow[tbl_addr[i]] = tbl_wdata[i];
            end
            else
                exp_rdata = shadow[tbl_addr[i]];

            check_nibble("rdata", exp_rdata, rdata);
            check_hits(tbl_class[i] == HIT_L1, tbl_class[i] == HIT_L2, hit_l1, hit_l2);
            check_latency(tbl_lat[i], cycles);
        end

        // The bound checks on the last done strobe finish one cycle later
        repeat (2) @(posedge clk);
        #1;
        if (cache_top_inst.cache_assert_inst.fail_count == 0)
        begin
            $display("Done: no errors");
            $finish;
        end
        else
        begin
            $display("Done: errors found");
            $fatal(1, "assertion failures during the run");
        end
    end

endmodule

//--- vlog.f
+incdir+include
hw/cache_pkg.sv
hw/l1_cache.sv
hw/l2_cache.sv
hw/main_memory.sv
hw/cache_ctrl.sv
hw/cache_top.sv
verif/cache_assert.sv
verif/cache_tb.sv
